//--- bit_corr_lane.sv
//////////////////////////////
// bit correlator lane
// +-1 code correlation of one signed
// sample stream in transposed adder form
// registered one-entry output stage
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "corr_consts.svh"

module bit_corr_lane #(
  parameter logic [`CORR_LEN-1:0] CODE = `CORR_CODE
) (
  input  logic              clk,
  input  logic              rst_n,

  // sample stream in
  input  logic              in_valid,
  output logic              in_ready,
  input  corr_pkg::sample_t in_sample,

  // result stream out
  output logic              out_valid,
  input  logic              out_ready,
  output corr_pkg::acc_t    out_acc
);

  import corr_pkg::*;

  // partial sum registers in the chain
  localparam int unsigned NSTAGE = `CORR_LEN - 1;

  //////////////////////////////
  // handshake
  //////////////////////////////

  logic advance;

  // one result held at most
  // a new sample may enter while the old result leaves
  assign in_ready = ~out_valid | out_ready;

  // chain and output move only on an accepted sample
  // stall freezes everything
  assign advance = in_valid & in_ready;

  //////////////////////////////
  // tap products
  //////////////////////////////

  acc_t sample_ext;
  acc_t tap [`CORR_LEN];

  // sign extend once, all taps share it
  assign sample_ext = acc_t'(in_sample);

  // code bit set adds the sample
  // code bit clear subtracts it
  always_comb begin
    for (int k = 0; k < `CORR_LEN; k++) begin
      tap[k] = CODE[k] ? sample_ext : -sample_ext;
    end
  end

  //////////////////////////////
  // transposed adder chain
  //////////////////////////////

  acc_t psum [NSTAGE];
  acc_t sum_next;

  // psum[j] holds the part of a future result
  // that still needs taps 0..j
  // oldest tap enters at the far end of the chain
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // history before reset counts as zero
      for (int j = 0; j < NSTAGE; j++) begin
        psum[j] <= '0;
      end
    end else if (advance) begin
      for (int j = 0; j < NSTAGE - 1; j++) begin
        psum[j] <= psum[j+1] + tap[j+1];
      end
      psum[NSTAGE-1] <= tap[NSTAGE];
    end
  end

  // newest sample closes the sum
  assign sum_next = psum[0] + tap[0];

  //////////////////////////////
  // output stage
  //////////////////////////////

  // valid rises one cycle after the sample is taken
  // falls when the result is taken and nothing new arrives
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (advance) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  // result word
  // held while out_ready is low
  always_ff @(posedge clk) begin
    if (advance) begin
      out_acc <= sum_next;
    end
  end

endmodule

`default_nettype wire

//--- corr_consts.svh
//////////////////////////////
// iq bit correlator constants
// sample and sum widths, code length,
// default spreading code, index width
//////////////////////////////
`ifndef CORR_CONSTS_SVH
`define CORR_CONSTS_SVH

// signed width of one I or Q sample
`define CORR_SAMPLE_W 6

// signed lane sum width
// worst case 16 x 32 = 512 so 12 bits never wrap
`define CORR_ACC_W 12

// number of taps in the spreading code
`define CORR_LEN 16

// default +-1 code, bit k is the tap k samples back
`define CORR_CODE 16'hB712

// unsigned |I|+|Q| width
`define CORR_MAG_W 13

// running result number
`define CORR_IDX_W 16

`endif

//--- corr_mag_detect.sv
//////////////////////////////
// magnitude and peak detect
// joins the I and Q lane results, forms
// |I|+|Q|, flags a peak at or above the
// threshold and numbers each result
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module corr_mag_detect (
  input  logic           clk,
  input  logic           rst_n,

  // I lane result
  input  logic           a_valid,
  output logic           a_ready,
  input  corr_pkg::acc_t a_acc,

  // Q lane result
  input  logic           b_valid,
  output logic           b_ready,
  input  corr_pkg::acc_t b_acc,

  // peak level
  input  corr_pkg::mag_t threshold,

  // combined result stream
  output logic           m_valid,
  input  logic           m_ready,
  output corr_pkg::acc_t m_i,
  output corr_pkg::acc_t m_q,
  output corr_pkg::mag_t m_mag,
  output logic           m_peak,
  output corr_pkg::idx_t m_index
);

  import corr_pkg::*;

  //////////////////////////////
  // join
  //////////////////////////////

  logic join_ready;
  logic pair_take;

  // same one-entry rule as the lanes
  assign join_ready = ~m_valid | m_ready;

  // a lane is only taken together with its partner
  assign a_ready = join_ready & b_valid;
  assign b_ready = join_ready & a_valid;

  assign pair_take = a_valid & b_valid & join_ready;

  //////////////////////////////
  // magnitude
  //////////////////////////////

  mag_t abs_i;
  mag_t abs_q;
  mag_t mag_sum;

  // lane sums stay within +-512, negation is safe
  assign abs_i = (a_acc < 0) ? mag_t'(-a_acc) : mag_t'(a_acc);
  assign abs_q = (b_acc < 0) ? mag_t'(-b_acc) : mag_t'(b_acc);

  // cheap |I|+|Q| estimate instead of a true modulus
  assign mag_sum = abs_i + abs_q;

  //////////////////////////////
  // output register
  //////////////////////////////

  idx_t idx_cnt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      m_valid <= 1'b0;
      idx_cnt <= '0;
    end else if (pair_take) begin
      m_valid <= 1'b1;
      // first result gets index 0
      idx_cnt <= idx_cnt + 1'b1;
    end else if (m_ready) begin
      m_valid <= 1'b0;
    end
  end

  // result payload, held under back-pressure
  always_ff @(posedge clk) begin
    if (pair_take) begin
      m_i     <= a_acc;
      m_q     <= b_acc;
      m_mag   <= mag_sum;
      m_peak  <= (mag_sum >= threshold);
      m_index <= idx_cnt;
    end
  end

endmodule

`default_nettype wire

//--- corr_pkg.sv
//////////////////////////////
// iq bit correlator types
// sample, lane sum, magnitude and
// result index words
//////////////////////////////
`default_nettype none

`include "corr_consts.svh"

package corr_pkg;

  // one signed I or Q input part
  typedef logic signed [`CORR_SAMPLE_W-1:0] sample_t;

  // signed correlation result of one lane
  typedef logic signed [`CORR_ACC_W-1:0] acc_t;

  // |I|+|Q| estimate, always positive
  typedef logic [`CORR_MAG_W-1:0] mag_t;

  // output result number
  // wraps at 2^16
  typedef logic [`CORR_IDX_W-1:0] idx_t;

endpackage

`default_nettype wire

//--- corr_scoreboard.sv
//////////////////////////////
// correlator scoreboard
// reference model of both lanes and the
// magnitude stage, checks every output
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "corr_consts.svh"

module corr_scoreboard #(
  parameter int BURST_INDEX = 0,
  parameter int QUIET_FIRST = 0,
  parameter int QUIET_LAST  = 0
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              s_valid,
  input  logic              s_ready,
  input  corr_pkg::sample_t s_i,
  input  corr_pkg::sample_t s_q,
  input  corr_pkg::mag_t    threshold,
  input  logic              m_valid,
  input  logic              m_ready,
  input  corr_pkg::acc_t    m_i,
  input  corr_pkg::acc_t    m_q,
  input  corr_pkg::mag_t    m_mag,
  input  logic              m_peak,
  input  corr_pkg::idx_t    m_index,
  output int                mismatch_errors,
  output int                other_errors,
  output int                out_count
);

  import corr_pkg::*;

  localparam logic [`CORR_LEN-1:0] CODE = `CORR_CODE;

  // sample histories
  // newest at index 0
  int hist_i [`CORR_LEN];
  int hist_q [`CORR_LEN];
  int exp_i_q [$];
  int exp_q_q [$];
  int in_count;
  // payload of the previous stalled cycle
  logic stall_prev;
  int held_i;
  int held_q;
  int held_mag;
  int held_peak;
  int held_index;

  // +1 tap where the code bit is set
  // -1 tap where it is clear
  function automatic int code_sum(input int hist [`CORR_LEN]);
    int acc;
    acc = 0;
    for (int k = 0; k < `CORR_LEN; k++) begin
      acc = CODE[k] ? acc + hist[k] : acc - hist[k];
    end
    return acc;
  endfunction

  function automatic int abs_int(input int v);
    return (v < 0) ? -v : v;
  endfunction

  task automatic check_value(input string name, input int got, input int expected);
    if (got != expected) begin
      mismatch_errors++;
      $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, expected);
    end
  endtask

  task automatic take_sample();
    for (int k = `CORR_LEN - 1; k > 0; k--) begin
      hist_i[k] = hist_i[k-1];
      hist_q[k] = hist_q[k-1];
    end
    hist_i[0] = int'(s_i);
    hist_q[0] = int'(s_q);
    exp_i_q.push_back(code_sum(hist_i));
    exp_q_q.push_back(code_sum(hist_q));
    in_count++;
  endtask

  task automatic check_output();
    int ei;
    int eq;
    int emag;
    if (exp_i_q.size() == 0) begin
      other_errors++;
      $display("error at %0t: output transfer with no expected result pending", $time);
      return;
    end
    ei = exp_i_q.pop_front();
    eq = exp_q_q.pop_front();
    emag = abs_int(ei) + abs_int(eq);
    check_value("m_i", int'(m_i), ei);
    check_value("m_q", int'(m_q), eq);
    check_value("m_mag", int'(m_mag), emag);
    check_value("m_peak", int'(m_peak), (emag >= int'(threshold)) ? 1 : 0);
    check_value("m_index", int'(m_index), out_count % 65536);
    // aligned burst gives the full code gain
    if (out_count == BURST_INDEX) begin
      check_value("m_i", int'(m_i), `CORR_LEN * 31);
      check_value("m_peak", int'(m_peak), 1);
    end
    if (out_count >= QUIET_FIRST && out_count <= QUIET_LAST && m_peak) begin
      other_errors++;
      $display("error at %0t: peak flagged on quiet result %0d", $time, out_count);
    end
    out_count++;
  endtask

  task automatic check_hold();
    if (!m_valid) begin
      other_errors++;
      $display("error at %0t: m_valid dropped while m_ready was low", $time);
    end else begin
      check_value("m_i (held)", int'(m_i), held_i);
      check_value("m_q (held)", int'(m_q), held_q);
      check_value("m_mag (held)", int'(m_mag), held_mag);
      check_value("m_peak (held)", int'(m_peak), held_peak);
      check_value("m_index (held)", int'(m_index), held_index);
    end
  endtask

  // sampled mid-cycle
  // handshakes complete at the next rising edge
  always @(negedge clk) begin
    if (!rst_n) begin
      for (int k = 0; k < `CORR_LEN; k++) begin
        hist_i[k] = 0;
        hist_q[k] = 0;
      end
      exp_i_q.delete();
      exp_q_q.delete();
      in_count = 0;
      out_count = 0;
      mismatch_errors = 0;
      other_errors = 0;
      stall_prev = 1'b0;
    end else begin
      if (stall_prev) check_hold();
      if (m_valid && in_count == 0) begin
        other_errors++;
        $display("error at %0t: m_valid high before any sample was accepted", $time);
      end
      if (s_valid && s_ready) take_sample();
      if (m_valid && m_ready) check_output();
      stall_prev = m_valid && !m_ready;
      held_i = int'(m_i);
      held_q = int'(m_q);
      held_mag = int'(m_mag);
      held_peak = int'(m_peak);
      held_index = int'(m_index);
    end
  end

endmodule

`default_nettype wire

//--- corr_stream_checker.sv
//////////////////////////////
// stream handshake checker
// protocol assertions on the correlator
// ports, bound into the top level
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module corr_stream_checker (
  input logic           clk,
  input logic           rst_n,
  input logic           s_ready,
  input logic           m_valid,
  input logic           m_ready,
  input corr_pkg::acc_t m_i,
  input corr_pkg::acc_t m_q,
  input corr_pkg::mag_t m_mag,
  input logic           m_peak,
  input corr_pkg::idx_t m_index
);

  // stalled result keeps valid and every payload field
  a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (m_valid && !m_ready) |=> (m_valid && $stable(m_i) && $stable(m_q)
      && $stable(m_mag) && $stable(m_peak) && $stable(m_index)))
    else $error("m_valid or payload changed while m_ready was low");

  // full pipe under output stall stays closed to new samples
  a_in_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (m_valid && !m_ready && !s_ready) |=> (m_ready || !s_ready))
    else $error("s_ready rose while the output stayed stalled");

  a_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown(m_valid))
    else $error("m_valid is unknown after reset");

  a_reset_idle: assert property (@(posedge clk) !rst_n |-> !m_valid)
    else $error("m_valid high during reset");

endmodule

bind iq_bit_corr_top corr_stream_checker u_stream_checker (
  .clk     (clk),
  .rst_n   (rst_n),
  .s_ready (s_ready),
  .m_valid (m_valid),
  .m_ready (m_ready),
  .m_i     (m_i),
  .m_q     (m_q),
  .m_mag   (m_mag),
  .m_peak  (m_peak),
  .m_index (m_index)
);

`default_nettype wire

//--- iq_bit_corr_top.sv
//////////////////////////////
// iq bit correlator top
// forks each I/Q sample into two lanes
// and joins them into the peak detector
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "corr_consts.svh"

module iq_bit_corr_top (
  input  logic              clk,
  input  logic              rst_n,

  // sample stream
  input  logic              s_valid,
  output logic              s_ready,
  input  corr_pkg::sample_t s_i,
  input  corr_pkg::sample_t s_q,

  input  corr_pkg::mag_t    threshold,

  // result stream
  output logic              m_valid,
  input  logic              m_ready,
  output corr_pkg::acc_t    m_i,
  output corr_pkg::acc_t    m_q,
  output corr_pkg::mag_t    m_mag,
  output logic              m_peak,
  output corr_pkg::idx_t    m_index
);

  import corr_pkg::*;

  logic i_in_valid;
  logic i_in_ready;
  logic q_in_valid;
  logic q_in_ready;
  logic i_out_valid;
  logic i_out_ready;
  logic q_out_valid;
  logic q_out_ready;
  acc_t i_acc;
  acc_t q_acc;

  //////////////////////////////
  // fork
  //////////////////////////////

  // each lane sees valid only when its partner can take too
  // keeps both chains on the same sample
  assign i_in_valid = s_valid & q_in_ready;
  assign q_in_valid = s_valid & i_in_ready;
  assign s_ready    = i_in_ready & q_in_ready;

  bit_corr_lane #(
    .CODE (`CORR_CODE)
  ) lane_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (i_in_valid),
    .in_ready  (i_in_ready),
    .in_sample (s_i),
    .out_valid (i_out_valid),
    .out_ready (i_out_ready),
    .out_acc   (i_acc)
  );

  bit_corr_lane #(
    .CODE (`CORR_CODE)
  ) lane_q (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (q_in_valid),
    .in_ready  (q_in_ready),
    .in_sample (s_q),
    .out_valid (q_out_valid),
    .out_ready (q_out_ready),
    .out_acc   (q_acc)
  );

  //////////////////////////////
  // join
  //////////////////////////////

  corr_mag_detect u_mag_detect (
    .clk       (clk),
    .rst_n     (rst_n),
    .a_valid   (i_out_valid),
    .a_ready   (i_out_ready),
    .a_acc     (i_acc),
    .b_valid   (q_out_valid),
    .b_ready   (q_out_ready),
    .b_acc     (q_acc),
    .threshold (threshold),
    .m_valid   (m_valid),
    .m_ready   (m_ready),
    .m_i       (m_i),
    .m_q       (m_q),
    .m_mag     (m_mag),
    .m_peak    (m_peak),
    .m_index   (m_index)
  );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run the iq bit correlator testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_iq_bit_corr \
  -Mdir obj_dir -o tb_sim

# the log decides the verdict
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Simulation PASSED$" sim.log; then
  echo "run_sim: pass"
  exit 0
fi
echo "run_sim: fail"
exit 1

//--- tb.f
+incdir+.
corr_pkg.sv
bit_corr_lane.sv
corr_mag_detect.sv
iq_bit_corr_top.sv
corr_stream_checker.sv
corr_scoreboard.sv
tb_iq_bit_corr.sv

//--- tb_iq_bit_corr.sv
//////////////////////////////
// iq bit correlator testbench
// random I/Q stream with back-pressure,
// a code-matched burst and a timeout
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "corr_consts.svh"

module tb_iq_bit_corr;

  import corr_pkg::*;

  localparam int N_RANDOM = 600;
  localparam int N_QUIET = 100;
  localparam int N_FLUSH = 4;
  localparam int N_TOTAL = N_RANDOM + `CORR_LEN + N_FLUSH;
  localparam int RESET_CYCLES = 16;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + 8 * N_RANDOM + 200;
  localparam logic [`CORR_LEN-1:0] CODE = `CORR_CODE;

  logic    clk;
  logic    rst_n;
  logic    s_valid;
  logic    s_ready;
  sample_t s_i;
  sample_t s_q;
  mag_t    threshold;
  logic    m_valid;
  logic    m_ready;
  acc_t    m_i;
  acc_t    m_q;
  mag_t    m_mag;
  logic    m_peak;
  idx_t    m_index;
  int      mismatch_errors;
  int      other_errors;
  int      out_count;
  logic [31:0] rng;
  int      cycle_count = 0;

  iq_bit_corr_top uut (
    .clk(clk), .rst_n(rst_n), .s_valid(s_valid), .s_ready(s_ready), .s_i(s_i), .s_q(s_q),
    .threshold(threshold), .m_valid(m_valid), .m_ready(m_ready), .m_i(m_i), .m_q(m_q),
    .m_mag(m_mag), .m_peak(m_peak), .m_index(m_index)
  );

  // quiet window excludes results that still see full-range samples
  corr_scoreboard #(
    .BURST_INDEX (N_RANDOM + `CORR_LEN - 1),
    .QUIET_FIRST (N_RANDOM - N_QUIET + `CORR_LEN - 1),
    .QUIET_LAST  (N_RANDOM - 1)
  ) u_scoreboard (
    .clk(clk), .rst_n(rst_n), .s_valid(s_valid), .s_ready(s_ready), .s_i(s_i), .s_q(s_q),
    .threshold(threshold), .m_valid(m_valid), .m_ready(m_ready), .m_i(m_i), .m_q(m_q),
    .m_mag(m_mag), .m_peak(m_peak), .m_index(m_index), .mismatch_errors(mismatch_errors),
    .other_errors(other_errors), .out_count(out_count)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  // next edge and new inputs 1 ns later
  // m_ready high about three cycles in four
  task automatic step_cycle();
    @(posedge clk);
    #1;
    rng = xorshift32(rng);
    m_ready = (rng[31:30] != 2'b00);
  endtask

  // optional idle gap
  // sample held until it is taken
  task automatic send_sample(input sample_t si, input sample_t sq);
    logic taken;
    rng = xorshift32(rng);
    if (rng[1:0] == 2'b00) begin
      s_valid = 1'b0;
      step_cycle();
    end
    s_valid = 1'b1;
    s_i = si;
    s_q = sq;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = s_ready;
      step_cycle();
    end
    s_valid = 1'b0;
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("error: timeout after %0d cycles with %0d of %0d results", cycle_count,
               out_count, N_TOTAL);
      $display("Simulation FAILED");
      $finish;
    end
  end

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    s_valid = 1'b0;
    s_i = '0;
    s_q = '0;
    threshold = mag_t'(400);
    m_ready = 1'b0;
    rng = 32'd76175;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // full-range samples first
    // small-amplitude tail after them
    for (int n = 0; n < N_RANDOM; n++) begin
      rng = xorshift32(rng);
      if (n < N_RANDOM - N_QUIET) begin
        send_sample(sample_t'(rng[5:0]), sample_t'(rng[11:6]));
      end else begin
        send_sample(sample_t'($signed(rng[1:0])), sample_t'($signed(rng[3:2])));
      end
    end
    // oldest burst sample meets the highest code bit
    for (int j = 0; j < `CORR_LEN; j++) begin
      send_sample(CODE[`CORR_LEN-1-j] ? sample_t'(31) : sample_t'(-31), '0);
    end
    repeat (N_FLUSH) send_sample('0, '0);
    while (out_count < N_TOTAL) step_cycle();
    $display("errors: mismatches=%0d other=%0d results=%0d", mismatch_errors,
             other_errors, out_count);
    if (mismatch_errors == 0 && other_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
